// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_astro_tiros
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
+incdir+tb
src/astro_pkg.sv
src/registra_jogada.sv
src/memoria_tiros.sv
src/move_tiros.sv
src/astro_tiros.sv
tb/tb_astro_tiros.sv

// ==== src/astro_pkg.sv ====
package astro_pkg;

    // grid of 16 by 16 cells
    localparam int COORD_W = 4;
    localparam logic [COORD_W-1:0] COORD_MAX = 4'd15;

    // shots leave from the ship
    localparam logic [COORD_W-1:0] NAVE_X = 4'd7;
    localparam logic [COORD_W-1:0] NAVE_Y = 4'd7;

    localparam int NUM_TIROS = 4;
    localparam int SLOT_W = 2;

    // keys 0..3 are up, down, right, left
    localparam int NUM_CHAVES = 5;
    localparam int CHAVE_TIRO = 4;

    typedef enum logic [1:0] {
        CIMA,
        BAIXO,
        DIREITA,
        ESQUERDA
    } direcao_t;

    typedef enum logic [1:0] {
        PARADO,
        MOVE,
        FIM
    } estado_mover_t;

endpackage

// ==== src/astro_tiros.sv ====
`timescale 1ns/100ps

module astro_tiros
    import astro_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [NUM_CHAVES-1:0] chaves,
    input  logic                  avancar,
    output logic [NUM_TIROS-1:0]  ocupados,
    output logic                  tiro_valido,
    output logic [SLOT_W-1:0]     tiro_slot,
    output logic [COORD_W-1:0]    tiro_x,
    output logic [COORD_W-1:0]    tiro_y,
    output logic                  tiro_ativo,
    output logic                  pronto
);

    logic               novo_tiro;
    direcao_t           novo_direcao;
    logic [SLOT_W-1:0]  le_slot;
    logic               le_carregado;
    logic [COORD_W-1:0] le_x;
    logic [COORD_W-1:0] le_y;
    direcao_t           le_direcao;
    logic               escreve;
    logic               escreve_carregado;
    logic [COORD_W-1:0] escreve_x;
    logic [COORD_W-1:0] escreve_y;

    registra_jogada registra_jogada (
        .clock        (clock),
        .reset        (reset),
        .chaves       (chaves),
        .novo_tiro    (novo_tiro),
        .novo_direcao (novo_direcao)
    );

    memoria_tiros memoria_tiros (
        .clock             (clock),
        .reset             (reset),
        .novo_tiro         (novo_tiro),
        .novo_direcao      (novo_direcao),
        .le_slot           (le_slot),
        .escreve           (escreve),
        .escreve_carregado (escreve_carregado),
        .escreve_x         (escreve_x),
        .escreve_y         (escreve_y),
        .le_carregado      (le_carregado),
        .le_x              (le_x),
        .le_y              (le_y),
        .le_direcao        (le_direcao),
        .ocupados          (ocupados)
    );

    move_tiros move_tiros (
        .clock             (clock),
        .reset             (reset),
        .avancar           (avancar),
        .le_carregado      (le_carregado),
        .le_x              (le_x),
        .le_y              (le_y),
        .le_direcao        (le_direcao),
        .le_slot           (le_slot),
        .escreve           (escreve),
        .escreve_carregado (escreve_carregado),
        .escreve_x         (escreve_x),
        .escreve_y         (escreve_y),
        .tiro_valido       (tiro_valido),
        .tiro_slot         (tiro_slot),
        .tiro_x            (tiro_x),
        .tiro_y            (tiro_y),
        .tiro_ativo        (tiro_ativo),
        .pronto            (pronto)
    );

endmodule

// ==== src/memoria_tiros.sv ====
`timescale 1ns/100ps

module memoria_tiros
    import astro_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 novo_tiro,
    input  direcao_t             novo_direcao,
    input  logic [SLOT_W-1:0]    le_slot,
    input  logic                 escreve,
    input  logic                 escreve_carregado,
    input  logic [COORD_W-1:0]   escreve_x,
    input  logic [COORD_W-1:0]   escreve_y,
    output logic                 le_carregado,
    output logic [COORD_W-1:0]   le_x,
    output logic [COORD_W-1:0]   le_y,
    output direcao_t             le_direcao,
    output logic [NUM_TIROS-1:0] ocupados
);

    logic [NUM_TIROS-1:0] carregado;
    logic [COORD_W-1:0]   pos_x [NUM_TIROS];
    logic [COORD_W-1:0]   pos_y [NUM_TIROS];
    direcao_t             dir_mem [NUM_TIROS];
    logic                 tem_livre;
    logic [SLOT_W-1:0]    slot_livre;
    logic                 insere;

    // lowest free slot is scanned from the top so slot 0 wins
    always_comb begin
        tem_livre  = 1'b0;
        slot_livre = '0;
        for (int i = NUM_TIROS - 1; i >= 0; i--) begin
            if (!carregado[i]) begin
                tem_livre  = 1'b1;
                slot_livre = SLOT_W'(i);
            end
        end
    end

    // full memory drops the shot
    assign insere = novo_tiro && tem_livre;

    always_ff @(posedge clock) begin
        if (reset) begin
            carregado <= '0;
        end else begin
            if (insere) begin
                carregado[slot_livre] <= 1'b1;
            end
            if (escreve) begin
                carregado[le_slot] <= escreve_carregado;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (insere) begin
            pos_x[slot_livre]   <= NAVE_X;
            pos_y[slot_livre]   <= NAVE_Y;
            dir_mem[slot_livre] <= novo_direcao;
        end
        if (escreve) begin
            pos_x[le_slot] <= escreve_x;
            pos_y[le_slot] <= escreve_y;
        end
    end

    // mover read port
    assign le_carregado = carregado[le_slot];
    assign le_x         = pos_x[le_slot];
    assign le_y         = pos_y[le_slot];
    assign le_direcao   = dir_mem[le_slot];
    assign ocupados     = carregado;

    // insert and mover write-back never hit the same slot
    a_insere_sem_colisao: assert property (
        @(posedge clock) disable iff (reset)
        (insere && escreve) |-> (le_slot != slot_livre)
    );

    // mover only writes back shots that are loaded
    a_escreve_carregado: assert property (
        @(posedge clock) disable iff (reset)
        escreve |-> carregado[le_slot]
    );

endmodule

// ==== src/move_tiros.sv ====
`timescale 1ns/100ps

module move_tiros
    import astro_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  logic               avancar,
    input  logic               le_carregado,
    input  logic [COORD_W-1:0] le_x,
    input  logic [COORD_W-1:0] le_y,
    input  direcao_t           le_direcao,
    output logic [SLOT_W-1:0]  le_slot,
    output logic               escreve,
    output logic               escreve_carregado,
    output logic [COORD_W-1:0] escreve_x,
    output logic [COORD_W-1:0] escreve_y,
    output logic               tiro_valido,
    output logic [SLOT_W-1:0]  tiro_slot,
    output logic [COORD_W-1:0] tiro_x,
    output logic [COORD_W-1:0] tiro_y,
    output logic               tiro_ativo,
    output logic               pronto
);

    estado_mover_t      estado;
    estado_mover_t      estado_prox;
    logic [SLOT_W-1:0]  slot;
    logic               na_borda;
    logic [COORD_W-1:0] prox_x;
    logic [COORD_W-1:0] prox_y;

    always_comb begin
        estado_prox = estado;
        case (estado)
            PARADO: begin
                if (avancar) begin
                    estado_prox = MOVE;
                end
            end
            MOVE: begin
                if (slot == SLOT_W'(NUM_TIROS - 1)) begin
                    estado_prox = FIM;
                end
            end
            FIM:     estado_prox = PARADO;
            default: estado_prox = PARADO;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            estado <= PARADO;
            slot   <= '0;
        end else begin
            estado <= estado_prox;
            // wraps back to 0 after the last slot
            if (estado == MOVE) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // one step along the heading or the border it faces
    always_comb begin
        prox_x   = le_x;
        prox_y   = le_y;
        na_borda = 1'b0;
        case (le_direcao)
            CIMA: begin
                na_borda = (le_y == '0);
                prox_y   = le_y - 1'b1;
            end
            BAIXO: begin
                na_borda = (le_y == COORD_MAX);
                prox_y   = le_y + 1'b1;
            end
            DIREITA: begin
                na_borda = (le_x == COORD_MAX);
                prox_x   = le_x + 1'b1;
            end
            ESQUERDA: begin
                na_borda = (le_x == '0);
                prox_x   = le_x - 1'b1;
            end
            default: na_borda = 1'b0;
        endcase
    end

    assign le_slot           = slot;
    assign escreve           = (estado == MOVE) && le_carregado;
    // shot leaving the grid is unloaded where it stands
    assign escreve_carregado = !na_borda;
    assign escreve_x         = na_borda ? le_x : prox_x;
    assign escreve_y         = na_borda ? le_y : prox_y;

    // result strobe mirrors the write-back
    assign tiro_valido = escreve;
    assign tiro_slot   = slot;
    assign tiro_x      = escreve_x;
    assign tiro_y      = escreve_y;
    assign tiro_ativo  = escreve && !na_borda;
    assign pronto      = (estado == FIM);

    a_pronto_pulso: assert property (
        @(posedge clock) disable iff (reset)
        pronto |=> !pronto
    );

endmodule

// ==== src/registra_jogada.sv ====
`timescale 1ns/100ps

module registra_jogada
    import astro_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [NUM_CHAVES-1:0] chaves,
    output logic                  novo_tiro,
    output direcao_t              novo_direcao
);

    logic [NUM_CHAVES-1:0] chaves_ant;
    logic [NUM_CHAVES-1:0] borda;
    direcao_t              direcao;
    direcao_t              direcao_prox;

    // rising edge on every key
    assign borda = chaves & ~chaves_ant;

    // up wins over down, down over right, right over left
    always_comb begin
        direcao_prox = direcao;
        if (borda[0]) begin
            direcao_prox = CIMA;
        end else if (borda[1]) begin
            direcao_prox = BAIXO;
        end else if (borda[2]) begin
            direcao_prox = DIREITA;
        end else if (borda[3]) begin
            direcao_prox = ESQUERDA;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            chaves_ant <= '0;
            direcao    <= CIMA;
            novo_tiro  <= 1'b0;
        end else begin
            chaves_ant <= chaves;
            direcao    <= direcao_prox;
            novo_tiro  <= borda[CHAVE_TIRO];
        end
    end

    // heading register already holds the update made with the fire edge
    assign novo_direcao = direcao;

endmodule

// ==== tb/modelo_tiros.svh ====
`ifndef MODELO_TIROS_SVH
`define MODELO_TIROS_SVH

// reference state of the four shot slots
logic [NUM_TIROS-1:0]  m_carregado;
logic [COORD_W-1:0]    m_x [NUM_TIROS];
logic [COORD_W-1:0]    m_y [NUM_TIROS];
direcao_t              m_dir [NUM_TIROS];
direcao_t              m_direcao;
logic [NUM_CHAVES-1:0] m_chaves_ant;

// 32 bit Fibonacci LFSR with taps 32 22 2 1
logic [31:0] lfsr = 32'd72942;

function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic void model_reset();
    m_carregado  = '0;
    m_direcao    = CIMA;
    m_chaves_ant = '0;
endfunction

function automatic void model_keys(input logic [NUM_CHAVES-1:0] v);
    logic [NUM_CHAVES-1:0] borda;
    int                    livre;
    borda        = v & ~m_chaves_ant;
    m_chaves_ant = v;
    livre        = -1;
    if (borda[0])
        m_direcao = CIMA;
    else if (borda[1])
        m_direcao = BAIXO;
    else if (borda[2])
        m_direcao = DIREITA;
    else if (borda[3])
        m_direcao = ESQUERDA;
    if (borda[CHAVE_TIRO]) begin
        for (int i = 0; i < NUM_TIROS; i++) begin
            if (!m_carregado[i] && livre < 0)
                livre = i;
        end
        // no free slot means the shot is lost
        if (livre >= 0) begin
            m_carregado[livre] = 1'b1;
            m_x[livre]         = NAVE_X;
            m_y[livre]         = NAVE_Y;
            m_dir[livre]       = m_direcao;
        end
    end
endfunction

function automatic void model_step(input int s, output logic [COORD_W-1:0] nx,
                                   output logic [COORD_W-1:0] ny, output logic ativo);
    int dx;
    int dy;
    int tx;
    int ty;
    dx = 0;
    dy = 0;
    case (m_dir[s])
        CIMA:    dy = -1;
        BAIXO:   dy = 1;
        DIREITA: dx = 1;
        default: dx = -1;
    endcase
    tx    = int'(m_x[s]) + dx;
    ty    = int'(m_y[s]) + dy;
    ativo = (tx >= 0) && (tx <= int'(COORD_MAX)) && (ty >= 0) && (ty <= int'(COORD_MAX));
    if (ativo) begin
        m_x[s] = tx[COORD_W-1:0];
        m_y[s] = ty[COORD_W-1:0];
    end else begin
        m_carregado[s] = 1'b0;
    end
    nx = m_x[s];
    ny = m_y[s];
endfunction

`endif

// ==== tb/tb_astro_tiros.sv ====
`timescale 1ns/100ps

module tb_astro_tiros
    import astro_pkg::*;
();

    // ~240 random ops at up to 9 cycles plus the directed phases
    localparam int TIMEOUT_CYCLES = 3000;

    logic                  clock;
    logic                  reset;
    logic [NUM_CHAVES-1:0] chaves;
    logic                  avancar;
    logic [NUM_TIROS-1:0]  ocupados;
    logic                  tiro_valido;
    logic [SLOT_W-1:0]     tiro_slot;
    logic [COORD_W-1:0]    tiro_x;
    logic [COORD_W-1:0]    tiro_y;
    logic                  tiro_ativo;
    logic                  pronto;
    int                    errors;
    int                    walks;
    int                    cycles;
    logic [NUM_CHAVES-1:0] dir_keys [4];

    `include "modelo_tiros.svh"

    astro_tiros dut (
        .clock       (clock),
        .reset       (reset),
        .chaves      (chaves),
        .avancar     (avancar),
        .ocupados    (ocupados),
        .tiro_valido (tiro_valido),
        .tiro_slot   (tiro_slot),
        .tiro_x      (tiro_x),
        .tiro_y      (tiro_y),
        .tiro_ativo  (tiro_ativo),
        .pronto      (pronto)
    );

    always #5 clock = ~clock;

    task automatic value_error(input string name, input int expected, input int actual);
        errors++;
        $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    endtask

    task automatic do_reset();
        @(posedge clock);
        reset   <= 1'b1;
        chaves  <= '0;
        avancar <= 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        model_reset();
    endtask

    // hold each key value for 7 cycles so fire edges never meet a walk
    task automatic set_keys(input logic [NUM_CHAVES-1:0] v);
        @(posedge clock);
        chaves <= v;
        model_keys(v);
        repeat (6) @(posedge clock);
    endtask

    task automatic walk(input string name, input bit extra);
        logic               exp_ok [NUM_TIROS];
        logic [COORD_W-1:0] exp_x [NUM_TIROS];
        logic [COORD_W-1:0] exp_y [NUM_TIROS];
        logic               exp_a [NUM_TIROS];
        logic               want_valid;
        for (int i = 0; i < NUM_TIROS; i++) begin
            exp_ok[i] = m_carregado[i];
            if (exp_ok[i])
                model_step(i, exp_x[i], exp_y[i], exp_a[i]);
        end
        walks++;
        @(posedge clock);
        avancar <= 1'b1;
        // slot n shows in cycle n+1 after the sampling edge and pronto in cycle 5
        for (int n = 0; n < 8; n++) begin
            @(posedge clock);
            avancar <= extra && (n == 2);
            @(negedge clock);
            want_valid = 1'b0;
            if (n < NUM_TIROS)
                want_valid = exp_ok[n];
            if (tiro_valido !== want_valid) begin
                value_error({name, " tiro_valido"}, int'(want_valid), int'(tiro_valido));
            end else if (want_valid) begin
                if (tiro_slot !== SLOT_W'(n))
                    value_error({name, " tiro_slot"}, n, int'(tiro_slot));
                if (tiro_x !== exp_x[n])
                    value_error({name, " tiro_x"}, int'(exp_x[n]), int'(tiro_x));
                if (tiro_y !== exp_y[n])
                    value_error({name, " tiro_y"}, int'(exp_y[n]), int'(tiro_y));
                if (tiro_ativo !== exp_a[n])
                    value_error({name, " tiro_ativo"}, int'(exp_a[n]), int'(tiro_ativo));
            end
            if (pronto !== (n == 4))
                value_error({name, " pronto"}, int'(n == 4), int'(pronto));
        end
        if (ocupados !== m_carregado)
            value_error({name, " ocupados"}, int'(m_carregado), int'(ocupados));
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        chaves   = '0;
        avancar  = 1'b0;
        errors   = 0;
        walks    = 0;
        // right, up, down, left
        dir_keys = '{5'b00100, 5'b00001, 5'b00010, 5'b01000};
        model_reset();

        do_reset();
        @(negedge clock);
        if (ocupados !== '0)
            value_error("reset ocupados", 0, int'(ocupados));
        walk("reset", 1'b0);

        do_reset();
        for (int d = 0; d < 4; d++) begin
            set_keys(dir_keys[d]);
            set_keys(dir_keys[d] | 5'b10000);
            set_keys('0);
            walk("heading", 1'b0);
        end

        do_reset();
        set_keys(5'b01000);
        set_keys(5'b11000);
        set_keys('0);
        repeat (9) walk("border", 1'b0);

        do_reset();
        repeat (4) begin
            set_keys(5'b10000);
            set_keys('0);
        end
        // fifth shot heads right and finds no free slot
        set_keys(5'b10100);
        set_keys('0);
        @(negedge clock);
        if (ocupados !== 4'b1111)
            value_error("full ocupados", 15, int'(ocupados));
        walk("full", 1'b0);
        walk("busy", 1'b1);
        walk("busy", 1'b0);

        do_reset();
        repeat (240) begin
            if (random_bits(2) == 0)
                walk("random", 1'b0);
            else
                set_keys(NUM_CHAVES'(random_bits(5)));
        end

        $display("%0d errors in %0d walks", errors, walks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
